// ==== include/arcade_cfg.svh ====
////////////////////
// widths, enable divider ratios and the host settings address map
// pulled in by the packages and by any module needing a constant
////////////////////

`ifndef ARCADE_CFG_SVH
`define ARCADE_CFG_SVH

// settings bus
`define CFG_ADDR_W 32
`define CFG_DATA_W 32

// cabinet side
`define CFG_KEY_W 16
`define CFG_PORT_W 8
`define CFG_RGB_W 24
`define CFG_SYNC_STAGES 3

// enable periods, in clk_40 cycles
`define CFG_CPU_DIV 10
`define CFG_SOUND_DIV 44
`define CFG_PIXEL_DIV 8

// address map, dip n at base + 16*(n-1)
`define CFG_ADDR_TEST 32'h0000_0000
`define CFG_ADDR_DIP_BASE 32'h0000_0010
`define CFG_ADDR_DIAG 32'h0000_0090

`endif

// ==== src/host_pkg.sv ====
////////////////////
// types for the host settings bus and the switch bank it fills
// imported by setting_regs and the top level
////////////////////

`include "arcade_cfg.svh"

package host_pkg;

  // settings bus address and data
  typedef logic [`CFG_ADDR_W-1:0] host_addr_t;
  typedef logic [`CFG_DATA_W-1:0] host_data_t;

  // dip 1 in bit 7, dip 8 in bit 0
  typedef logic [7:0] dip_t;

endpackage

// ==== src/cab_pkg.sv ====
////////////////////
// cabinet side types: controller keys, board ports, pixels
// and the settings responder state encoding
////////////////////

`include "arcade_cfg.svh"

package cab_pkg;

  typedef logic [`CFG_KEY_W-1:0] key_t;
  typedef logic [`CFG_PORT_W-1:0] port_t;
  // red in the top byte, blue in the bottom
  typedef logic [`CFG_RGB_W-1:0] rgb_t;

  // key bitmap positions
  localparam int KEY_UP = 0;
  localparam int KEY_DOWN = 1;
  localparam int KEY_LEFT = 2;
  localparam int KEY_RIGHT = 3;
  localparam int KEY_A = 4;
  localparam int KEY_X = 6;
  localparam int KEY_SELECT = 14;
  localparam int KEY_START = 15;

  // four-phase responder
  typedef enum logic {
    BUS_IDLE,
    BUS_ACK
  } bus_state_t;

endpackage

// ==== src/setting_regs.sv ====
////////////////////
// host settings bank behind a four-phase req/ack bus
// one switch per address, bit 0 of the data word
////////////////////

`timescale 1ns/1ps
`include "arcade_cfg.svh"

module setting_regs import host_pkg::*, cab_pkg::*; (
  input  logic       clk_40,
  input  logic       arst_n,
  input  logic       bus_req,
  input  logic       bus_wr,
  input  host_addr_t bus_addr,
  input  host_data_t bus_wdata,
  output logic       bus_ack,
  output host_data_t bus_rdata,
  output logic       test_mode,
  output logic       diagonal,
  output dip_t       dip
);

  bus_state_t state;
  logic       take;
  logic       sel_test;
  logic       sel_diag;
  dip_t       sel_dip;
  logic       rd_bit;

  // address decode, dip 1 lands in the msb
  always_comb begin
    sel_test = (bus_addr == host_addr_t'(`CFG_ADDR_TEST));
    sel_diag = (bus_addr == host_addr_t'(`CFG_ADDR_DIAG));
    for (int n = 0; n < 8; n++) begin
      sel_dip[7-n] = (bus_addr == host_addr_t'(`CFG_ADDR_DIP_BASE + 16 * n));
    end
  end

  // unmapped addresses fall out as zero
  assign rd_bit = (sel_test & test_mode) | (sel_diag & diagonal) | (|(sel_dip & dip));

  // new transfer seen while idle
  assign take = (state == BUS_IDLE) && bus_req;
  assign bus_ack = (state == BUS_ACK);

  ////////////////////
  // handshake and switches
  ////////////////////
  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      state <= BUS_IDLE;
      test_mode <= 1'b0;
      diagonal <= 1'b0;
      dip <= '0;
    end else begin
      case (state)
        BUS_IDLE: if (bus_req) state <= BUS_ACK;
        BUS_ACK: if (!bus_req) state <= BUS_IDLE;
        default: state <= BUS_IDLE;
      endcase
      // write lands on the same edge ack rises
      if (take && bus_wr) begin
        if (sel_test) test_mode <= bus_wdata[0];
        if (sel_diag) diagonal <= bus_wdata[0];
        for (int i = 0; i < 8; i++) begin
          if (sel_dip[i]) dip[i] <= bus_wdata[0];
        end
      end
    end
  end

  // read word, held for the whole ack phase
  always_ff @(posedge clk_40) begin
    if (take) bus_rdata <= host_data_t'(rd_bit);
  end

endmodule

// ==== src/control_mapper.sv ====
////////////////////
// player one keys into the clk_40 domain, then onto
// the board input ports ip1710 and ip4740
////////////////////

`timescale 1ns/1ps
`include "arcade_cfg.svh"

module control_mapper import cab_pkg::*; (
  input  logic  clk_40,
  input  logic  arst_n,
  input  key_t  key,
  input  logic  test_mode,
  input  logic  diagonal,
  output port_t ip1710,
  output port_t ip4740
);

  key_t sync_q [`CFG_SYNC_STAGES];
  key_t k;

  // synchronizer chain
  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CFG_SYNC_STAGES; i++) sync_q[i] <= '0;
    end else begin
      sync_q[0] <= key;
      for (int i = 1; i < `CFG_SYNC_STAGES; i++) sync_q[i] <= sync_q[i-1];
    end
  end

  assign k = sync_q[`CFG_SYNC_STAGES-1];

  // test inputs, coin and the two start buttons
  // test_mode is active low on the board
  assign ip1710 = {k[KEY_A], ~test_mode, 2'b00, k[KEY_SELECT], 1'b0, k[KEY_X], k[KEY_START]};

  ////////////////////
  // joystick port
  ////////////////////
  always_comb begin
    if (diagonal) begin
      // stick turned 45 degrees
      ip4740 = {4'b0000,
                k[KEY_DOWN] & k[KEY_LEFT],
                k[KEY_RIGHT] & k[KEY_UP],
                k[KEY_UP] & k[KEY_LEFT],
                k[KEY_RIGHT] & k[KEY_DOWN]};
    end else begin
      ip4740 = {4'b0000, k[KEY_DOWN], k[KEY_UP], k[KEY_LEFT], k[KEY_RIGHT]};
    end
  end

endmodule

// ==== src/clock_enables.sv ====
////////////////////
// cpu, sound and pixel enables from clk_40
// each a one cycle pulse per period
////////////////////

`timescale 1ns/1ps
`include "arcade_cfg.svh"

module clock_enables (
  input  logic clk_40,
  input  logic arst_n,
  output logic cpu_ce,
  output logic sound_ce,
  output logic pixel_ce
);

  // order: cpu, sound, pixel
  localparam int unsigned PERIOD [3] = '{`CFG_CPU_DIV, `CFG_SOUND_DIV, `CFG_PIXEL_DIV};
  // sound has the longest period
  localparam int CNT_W = $clog2(`CFG_SOUND_DIV);

  logic [CNT_W-1:0] cnt [3];
  logic [2:0]       ce;

  for (genvar g = 0; g < 3; g++) begin : g_div
    // wrap at period-1, pulse on the following cycle
    always_ff @(posedge clk_40 or negedge arst_n) begin
      if (!arst_n) begin
        cnt[g] <= '0;
        ce[g] <= 1'b0;
      end else begin
        ce[g] <= (cnt[g] == CNT_W'(PERIOD[g] - 1));
        cnt[g] <= (cnt[g] == CNT_W'(PERIOD[g] - 1)) ? '0 : cnt[g] + 1'b1;
      end
    end
  end

  assign cpu_ce = ce[0];
  assign sound_ce = ce[1];
  assign pixel_ce = ce[2];

endmodule

// ==== src/video_out.sv ====
////////////////////
// pixel rate output register for the scaler
// blanks color outside the active area, sync levels to pulses
////////////////////

`timescale 1ns/1ps
`include "arcade_cfg.svh"

module video_out import cab_pkg::*; (
  input  logic clk_40,
  input  logic arst_n,
  input  logic pixel_ce,
  input  rgb_t rgb_in,
  input  logic hblank,
  input  logic vblank,
  input  logic hs_in,
  input  logic vs_in,
  output rgb_t video_rgb,
  output logic video_de,
  output logic video_hs,
  output logic video_vs
);

  logic active;
  logic hs_prev;
  logic vs_prev;

  assign active = ~(hblank | vblank);

  always_ff @(posedge clk_40 or negedge arst_n) begin
    if (!arst_n) begin
      video_rgb <= '0;
      video_de <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
    end else if (pixel_ce) begin
      // color only inside the active window
      video_de <= active;
      video_rgb <= active ? rgb_in : '0;
      // rising edge of sync, one pixel wide
      video_hs <= hs_in & ~hs_prev;
      video_vs <= vs_in & ~vs_prev;
      hs_prev <= hs_in;
      vs_prev <= vs_in;
    end
  end

endmodule

// ==== src/arcade_shell_top.sv ====
////////////////////
// cabinet facing shell of the arcade core
// settings bank, controls, enables and video out on clk_40
////////////////////

`timescale 1ns/1ps
`include "arcade_cfg.svh"

module arcade_shell_top import host_pkg::*, cab_pkg::*; (
  input  logic       clk_40,
  input  logic       arst_n,
  // host settings bus
  input  logic       bus_req,
  input  logic       bus_wr,
  input  host_addr_t bus_addr,
  input  host_data_t bus_wdata,
  output logic       bus_ack,
  output host_data_t bus_rdata,
  // switches out to the board
  output logic       test_mode,
  output logic       diagonal,
  output dip_t       dip,
  // controller and board ports
  input  key_t       key,
  output port_t      ip1710,
  output port_t      ip4740,
  // enables for the board
  output logic       cpu_ce,
  output logic       sound_ce,
  // video from the board, then to the scaler
  input  rgb_t       rgb_in,
  input  logic       hblank,
  input  logic       vblank,
  input  logic       hs_in,
  input  logic       vs_in,
  output rgb_t       video_rgb,
  output logic       video_de,
  output logic       video_hs,
  output logic       video_vs
);

  logic pixel_ce;

  ////////////////////
  // settings
  ////////////////////
  setting_regs u_setting_regs (
    .clk_40    (clk_40),
    .arst_n    (arst_n),
    .bus_req   (bus_req),
    .bus_wr    (bus_wr),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_ack   (bus_ack),
    .bus_rdata (bus_rdata),
    .test_mode (test_mode),
    .diagonal  (diagonal),
    .dip       (dip)
  );

  // player one only
  control_mapper u_control_mapper (
    .clk_40    (clk_40),
    .arst_n    (arst_n),
    .key       (key),
    .test_mode (test_mode),
    .diagonal  (diagonal),
    .ip1710    (ip1710),
    .ip4740    (ip4740)
  );

  clock_enables u_clock_enables (
    .clk_40   (clk_40),
    .arst_n   (arst_n),
    .cpu_ce   (cpu_ce),
    .sound_ce (sound_ce),
    .pixel_ce (pixel_ce)
  );

  ////////////////////
  // video
  ////////////////////
  video_out u_video_out (
    .clk_40    (clk_40),
    .arst_n    (arst_n),
    .pixel_ce  (pixel_ce),
    .rgb_in    (rgb_in),
    .hblank    (hblank),
    .vblank    (vblank),
    .hs_in     (hs_in),
    .vs_in     (vs_in),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
  );

endmodule

// ==== testbench/tb_clock.sv ====
////////////////////
// testbench clock and reset source
// 10 ns clk_40, arst_n held low for 16 cycles
////////////////////

`timescale 1ns/1ps

module tb_clock (
  output logic clk_40,
  output logic arst_n
);

  initial begin
    clk_40 = 1'b0;
    forever #5 clk_40 = ~clk_40;
  end

  // release just after the 16th rising edge
  initial begin
    arst_n = 1'b0;
    repeat (16) @(posedge clk_40);
    #1 arst_n = 1'b1;
  end

endmodule

// ==== testbench/arcade_assertions.sv ====
////////////////////
// concurrent checks on the settings handshake, cpu enable
// spacing and video blanking, bound into the shell top
////////////////////

`timescale 1ns/1ps

module arcade_assertions import cab_pkg::*; (
  input logic clk_40,
  input logic arst_n,
  input logic bus_req,
  input logic bus_ack,
  input logic cpu_ce,
  input rgb_t video_rgb,
  input logic video_de
);

  // failures so far, summed for the testbench
  int ack_fails = 0;
  int ce_fails = 0;
  int blank_fails = 0;
  int fail_count;

  assign fail_count = ack_fails + ce_fails + blank_fails;

  // ack only answers a pending req
  ack_needs_req: assert property (@(posedge clk_40) disable iff (!arst_n)
    $rose(bus_ack) |-> $past(bus_req))
    else begin
      $error("bus_ack rose without bus_req high");
      ack_fails++;
    end

  // no second cpu pulse inside one period of 10
  cpu_ce_spacing: assert property (@(posedge clk_40) disable iff (!arst_n)
    cpu_ce |-> !($past(cpu_ce, 1) || $past(cpu_ce, 2) || $past(cpu_ce, 3) ||
                 $past(cpu_ce, 4) || $past(cpu_ce, 5) || $past(cpu_ce, 6) ||
                 $past(cpu_ce, 7) || $past(cpu_ce, 8) || $past(cpu_ce, 9)))
    else begin
      $error("cpu_ce repeated within 10 cycles");
      ce_fails++;
    end

  // blanked pixels carry no color
  rgb_dark_when_blank: assert property (@(posedge clk_40) disable iff (!arst_n)
    !video_de |-> (video_rgb == '0))
    else begin
      $error("video_rgb not zero while video_de is low");
      blank_fails++;
    end

endmodule

// handshake signals come from setting_regs, the video pair from video_out
bind arcade_shell_top arcade_assertions u_assert (
  .clk_40    (clk_40),
  .arst_n    (arst_n),
  .bus_req   (bus_req),
  .bus_ack   (bus_ack),
  .cpu_ce    (cpu_ce),
  .video_rgb (video_rgb),
  .video_de  (video_de)
);

// ==== testbench/arcade_tb.sv ====
////////////////////
// directed testbench for the arcade shell top
// settings bus, key mapping, enables and the video stage
////////////////////

`timescale 1ns/1ps
`include "arcade_cfg.svh"

module arcade_tb import host_pkg::*, cab_pkg::*; ();

  // reset and tests take about 870 cycles, limit kept well clear of it
  localparam int TIMEOUT_CYCLES = 20000;

  logic clk_40;
  logic arst_n;
  logic bus_req, bus_wr, bus_ack;
  host_addr_t bus_addr;
  host_data_t bus_wdata, bus_rdata;
  logic test_mode, diagonal;
  dip_t dip;
  key_t key;
  port_t ip1710, ip4740;
  logic cpu_ce, sound_ce;
  rgb_t rgb_in, video_rgb;
  logic hblank, vblank, hs_in, vs_in;
  logic video_de, video_hs, video_vs;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int hs_cycles, vs_cycles;
  integer seed;
  string test_name;
  // switch model: 0 test, 1..8 dip n, 9 diagonal
  logic sw_model [10];
  logic [15:0] diag_keys [4] = '{16'h0005, 16'h0009, 16'h0006, 16'h000A};

  tb_clock u_clock (.clk_40(clk_40), .arst_n(arst_n));

  arcade_shell_top uut (.*);

  task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // inputs move 1 ns after the edge, outputs are read there too
  task automatic next_cycle();
    @(posedge clk_40);
    #1;
  endtask

  function automatic logic [31:0] switch_addr(int s);
    if (s == 0) return `CFG_ADDR_TEST;
    if (s == 9) return `CFG_ADDR_DIAG;
    return `CFG_ADDR_DIP_BASE + 32'(16 * (s - 1));
  endfunction

  // -1 for an unmapped address
  function automatic int switch_of(logic [31:0] addr);
    for (int s = 0; s < 10; s++) begin
      if (switch_addr(s) == addr) return s;
    end
    return -1;
  endfunction

  // board port tables
  function automatic logic [7:0] exp_ip1710(logic [15:0] k, logic tm);
    logic [7:0] p;
    p = 8'h00;
    p[7] = k[4];
    p[6] = ~tm;
    p[3] = k[14];
    p[1] = k[6];
    p[0] = k[15];
    return p;
  endfunction

  function automatic logic [7:0] exp_ip4740(logic [15:0] k, logic diag);
    logic up, down, left, right;
    up = k[0];
    down = k[1];
    left = k[2];
    right = k[3];
    if (diag) return {4'h0, down & left, right & up, up & left, right & down};
    return {4'h0, down, up, left, right};
  endfunction

  ////////////////////
  // host bus
  ////////////////////
  task automatic bus_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    bus_wr = wr;
    bus_addr = addr;
    bus_wdata = wdata;
    bus_req = 1'b1;
    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (!bus_ack && waited < 16);
    check("cycles to ack rise", 32'd1, 32'(waited));
    rdata = bus_rdata;
    bus_req = 1'b0;
    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (bus_ack && waited < 16);
    check("cycles to ack fall", 32'd1, 32'(waited));
  endtask

  // junk in the upper bits, only bit 0 counts
  task automatic write_setting(logic [31:0] addr, logic value);
    logic [31:0] rd;
    int s;
    s = switch_of(addr);
    bus_transfer(1'b1, addr, value ? 32'hA5A5_A5A5 : 32'h5A5A_5A5A, rd);
    if (s >= 0) sw_model[s] = value;
  endtask

  task automatic read_setting(logic [31:0] addr);
    logic [31:0] rd;
    int s;
    s = switch_of(addr);
    bus_transfer(1'b0, addr, 32'hFFFF_FFFF, rd);
    check($sformatf("read %h", addr), (s >= 0) ? 32'(sw_model[s]) : 32'h0, rd);
  endtask

  // dip 1 in the msb
  task automatic check_switches();
    logic [7:0] exp_dip;
    for (int n = 1; n <= 8; n++) exp_dip[8-n] = sw_model[n];
    check("test_mode", 32'(sw_model[0]), 32'(test_mode));
    check("diagonal", 32'(sw_model[9]), 32'(diagonal));
    check("dip", 32'(exp_dip), 32'(dip));
  endtask

  task automatic track_pulse(string what, logic hit, int i, int period,
                             inout int last, inout int count);
    if (hit) begin
      if (last >= 0) check({what, " spacing"}, 32'(period), 32'(i - last));
      last = i;
      count++;
    end
  endtask

  // one pixel held over a whole pixel period
  task automatic show_pixel(rgb_t rgb, logic hb, logic vb, logic hs, logic vs);
    rgb_in = rgb;
    hblank = hb;
    vblank = vb;
    hs_in = hs;
    vs_in = vs;
    repeat (8) begin
      next_cycle();
      if (video_hs) hs_cycles++;
      if (video_vs) vs_cycles++;
    end
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic test_reset_values();
    test_name = "reset_values";
    check("ip1710", 32'(exp_ip1710(16'h0, 1'b0)), 32'(ip1710));
    check("ack", 32'd0, 32'(bus_ack));
    // enables still counting their first period
    for (int i = 0; i < 7; i++) begin
      next_cycle();
      check("cpu_ce", 32'd0, 32'(cpu_ce));
      check("sound_ce", 32'd0, 32'(sound_ce));
      check("video sync and de", 32'd0, 32'({video_de, video_hs, video_vs}));
      check("video_rgb", 32'd0, 32'(video_rgb));
    end
    for (int s = 0; s < 10; s++) read_setting(switch_addr(s));
    check_switches();
  endtask

  task automatic test_settings_bank();
    test_name = "settings_bank";
    // one switch at a time, so a wrong bit position shows
    for (int s = 0; s < 10; s++) begin
      write_setting(switch_addr(s), 1'b1);
      read_setting(switch_addr(s));
      check_switches();
      write_setting(switch_addr(s), 1'b0);
      read_setting(switch_addr(s));
    end
    write_setting(switch_addr(1), 1'b1);
    write_setting(switch_addr(3), 1'b1);
    write_setting(switch_addr(8), 1'b1);
    check("dip 1, 3 and 8", 32'h0000_00A1, 32'(dip));
    // unmapped, must not disturb the bank
    write_setting(32'h0000_00A0, 1'b1);
    read_setting(32'h0000_00A0);
    write_setting(32'h0000_0014, 1'b1);
    read_setting(32'h0000_0014);
    check_switches();
  endtask

  task automatic test_controller_mapping();
    logic [31:0] rnd;
    logic [15:0] k, prev_k;
    test_name = "controller_mapping";
    prev_k = key;
    for (int mode = 0; mode < 4; mode++) begin
      write_setting(`CFG_ADDR_TEST, mode[0]);
      write_setting(`CFG_ADDR_DIAG, mode[1]);
      for (int i = 0; i < 16; i++) begin
        rnd = $random(seed);
        k = (i < 4) ? diag_keys[i] : rnd[15:0];
        key = k;
        // old key still on the ports after two edges
        repeat (2) next_cycle();
        check("ip4740 before sync", 32'(exp_ip4740(prev_k, mode[1])), 32'(ip4740));
        next_cycle();
        check("ip1710", 32'(exp_ip1710(k, mode[0])), 32'(ip1710));
        check("ip4740", 32'(exp_ip4740(k, mode[1])), 32'(ip4740));
        prev_k = k;
      end
    end
  endtask

  task automatic test_clock_enables();
    int cpu_n, snd_n, pix_n;
    int cpu_last, snd_last, pix_last;
    rgb_t last_rgb;
    test_name = "clock_enables";
    cpu_n = 0;
    snd_n = 0;
    pix_n = 0;
    cpu_last = -1;
    snd_last = -1;
    pix_last = -1;
    hblank = 1'b0;
    vblank = 1'b0;
    last_rgb = video_rgb;
    // fresh color every cycle, so each pixel sample shows as a change
    for (int i = 0; i < 440; i++) begin
      rgb_in = 24'h5A_0000 | rgb_t'(i);
      next_cycle();
      track_pulse("cpu_ce", cpu_ce, i, `CFG_CPU_DIV, cpu_last, cpu_n);
      track_pulse("sound_ce", sound_ce, i, `CFG_SOUND_DIV, snd_last, snd_n);
      track_pulse("pixel", video_rgb !== last_rgb, i, `CFG_PIXEL_DIV, pix_last, pix_n);
      last_rgb = video_rgb;
    end
    check("cpu_ce pulses", 32'd44, 32'(cpu_n));
    check("sound_ce pulses", 32'd10, 32'(snd_n));
    check("pixel updates", 32'd55, 32'(pix_n));
  endtask

  task automatic test_video_stage();
    test_name = "video_stage";
    show_pixel(24'h123456, 1'b1, 1'b0, 1'b0, 1'b0);
    check("hblank de", 32'd0, 32'(video_de));
    check("hblank rgb", 32'd0, 32'(video_rgb));
    show_pixel(24'h654321, 1'b0, 1'b1, 1'b0, 1'b0);
    check("vblank de", 32'd0, 32'(video_de));
    check("vblank rgb", 32'd0, 32'(video_rgb));
    show_pixel(24'hC0FFEE, 1'b0, 1'b0, 1'b0, 1'b0);
    check("active de", 32'd1, 32'(video_de));
    check("active rgb", 32'h00C0_FFEE, 32'(video_rgb));
    // hs step, then held high
    hs_cycles = 0;
    show_pixel(24'h0A0B0C, 1'b0, 1'b0, 1'b1, 1'b0);
    check("hs after step", 32'd1, 32'(video_hs));
    show_pixel(24'h0A0B0C, 1'b0, 1'b0, 1'b1, 1'b0);
    check("hs held high", 32'd0, 32'(video_hs));
    show_pixel(24'h0A0B0C, 1'b0, 1'b0, 1'b1, 1'b0);
    check("hs pulse cycles", 32'd8, 32'(hs_cycles));
    // vs step while hs falls
    vs_cycles = 0;
    show_pixel(24'h0D0E0F, 1'b0, 1'b0, 1'b0, 1'b1);
    check("vs after step", 32'd1, 32'(video_vs));
    check("hs on falling input", 32'd0, 32'(video_hs));
    show_pixel(24'h0D0E0F, 1'b0, 1'b0, 1'b0, 1'b1);
    check("vs held high", 32'd0, 32'(video_vs));
    show_pixel(24'h0D0E0F, 1'b0, 1'b0, 1'b0, 1'b1);
    check("vs pulse cycles", 32'd8, 32'(vs_cycles));
  endtask

  // watchdog
  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_40);
      cycles++;
    end
    $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    seed = 32'h8b1b_9909;
    bus_req = 1'b0;
    bus_wr = 1'b0;
    bus_addr = '0;
    bus_wdata = '0;
    key = '0;
    rgb_in = '0;
    hblank = 1'b1;
    vblank = 1'b1;
    hs_in = 1'b0;
    vs_in = 1'b0;
    for (int s = 0; s < 10; s++) sw_model[s] = 1'b0;
    wait (arst_n === 1'b1);
    test_reset_values();
    test_settings_bank();
    test_controller_mapping();
    test_clock_enables();
    test_video_stage();
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, uut.u_assert.fail_count);
    if (errors == 0 && uut.u_assert.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
src/host_pkg.sv
src/cab_pkg.sv
src/setting_regs.sv
src/control_mapper.sv
src/clock_enables.sv
src/video_out.sv
src/arcade_shell_top.sv
testbench/tb_clock.sv
testbench/arcade_assertions.sv
testbench/arcade_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the arcade shell testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module arcade_tb -Mdir obj_dir -o arcade_sim
if [ $? -ne 0 ]; then
  echo "run_sim: build failed"
  exit 1
fi

./obj_dir/arcade_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "run_sim: simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  echo "run_sim: FAIL"
  exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
  echo "run_sim: no result line in $LOG"
  exit 1
fi
echo "run_sim: PASS"
exit 0
